/* matmul2x2.f */
hw/matmul_pkg.sv
hw/mm_dp_if.sv
hw/mm_host_regs.sv
hw/mm_control.sv
hw/mm_datapath.sv
hw/mm_top.sv
verification/mm_tb.sv

/* verification/mm_tb.sv */
`timescale 1ns/1ps

module mm_tb;
  import matmul_pkg::*;

  localparam int clk_period      = 10;
  localparam int num_jobs        = 24;                   // 1 directed, 20 random, 2 status, 1 busy
  localparam int watchdog_cycles = 40 * num_jobs + 200;  // Margin covers reset and idle waits
  localparam int job_limit       = 20;                   // Cycles allowed from go to write

  logic      clk = 1'b0;
  logic      rst_n;
  addr_t     mem_addr;
  line_t     mem_wdata;
  be_t       mem_be;
  logic      mem_rd;
  logic      mem_wr;
  line_t     mem_rdata;
  reg_file_t host_regs;
  reg_mask_t host_regs_valid_pulse;
  reg_file_t host_regs_data_out;
  reg_mask_t host_regs_valid_out;

  logic [255:0] mem_arr [256];  // Scratch memory model with byte b at bits 8b+7..8b
  logic [255:0] wdata_flat;     // Write data seen byte-wise
  int unsigned  cycle_cnt = 0;  // Rising edges so far
  int unsigned  rd_cnt = 0;     // Reads served
  int unsigned  wr_cnt = 0;     // Writes applied
  int unsigned  wr_edge;        // Edge count at the last write
  addr_t        wr_addr;
  be_t          wr_be;
  word_t        lcg_state = 32'hd56f;
  int           err_cnt = 0;
  int           check_cnt = 0;
  int           test_cnt = 0;
  int           fail_cnt = 0;

  always #(clk_period / 2) clk = ~clk;

  mm_top mm_top_inst (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .mem_addr              (mem_addr),
    .mem_wdata             (mem_wdata),
    .mem_be                (mem_be),
    .mem_rd                (mem_rd),
    .mem_wr                (mem_wr),
    .mem_rdata             (mem_rdata),
    .host_regs             (host_regs),
    .host_regs_valid_pulse (host_regs_valid_pulse),
    .host_regs_data_out    (host_regs_data_out),
    .host_regs_valid_out   (host_regs_valid_out)
  );

  // --------------------------------------------------
  // Memory model with read data one cycle after mem_rd
  // --------------------------------------------------
  assign wdata_flat = mem_wdata;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (mem_rd) begin
      mem_rdata <= mem_arr[mem_addr];
      rd_cnt    <= rd_cnt + 1;
    end
    if (mem_wr) begin
      for (int b = 0; b < bytes_per_line; b++) begin
        if (mem_be[b])
          mem_arr[mem_addr][b*8 +: 8] <= wdata_flat[b*8 +: 8];  // Masked bytes keep old data
      end
      wr_cnt  <= wr_cnt + 1;
      wr_edge <= cycle_cnt;
      wr_addr <= mem_addr;
      wr_be   <= mem_be;
    end
  end

  // Line and word index both enter the pattern
  task automatic fill_memory();
    for (int a = 0; a < 256; a++) begin
      for (int w = 0; w < words_per_line; w++)
        mem_arr[a][w*32 +: 32] = {8'(a), 8'(w), 16'h5a3c} ^ (a * 32'h0101_0007);
    end
  endtask

  // --------------------------------------------------
  // Reference model and random source
  // --------------------------------------------------
  function automatic mat_t ref_mul(input mat_t a, input mat_t b);
    mat_t        c;
    logic [63:0] acc;
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < 2; j++) begin
        acc = '0;
        for (int k = 0; k < 2; k++)
          acc += a[2*i+k] * b[2*k+j];  // Row i of A times column j of B
        c[2*i+j] = acc[31:0];          // Modulo 2^32
      end
    end
    return c;
  endfunction

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic mat_t make_mat(input word_t e11, input word_t e12,
                                    input word_t e21, input word_t e22);
    mat_t m;
    m[0] = e11;
    m[1] = e12;
    m[2] = e21;
    m[3] = e22;
    return m;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic compare_word(input string name, input word_t got, input word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_be(input string name, input be_t got, input be_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_mask(input string name, input reg_mask_t got, input reg_mask_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // --------------------------------------------------
  // One job from go to status update
  // --------------------------------------------------
  task automatic run_job(input mat_t a, input mat_t b, input bit extra_go);
    logic [255:0] old_line;
    mat_t         exp_c;
    int unsigned  wr_start;
    int unsigned  go_edge;
    int           waited;
    reg_mask_t    busy_only;
    busy_only = '0;
    busy_only[busy_reg_idx] = 1'b1;
    mem_arr[src_line] = {b, a};  // A in words 0-3
    old_line = mem_arr[dst_line];
    exp_c    = ref_mul(a, b);
    wr_start = wr_cnt;
    @(posedge clk);
    host_regs[go_reg_idx]             <= 32'h1;
    host_regs_valid_pulse[go_reg_idx] <= 1'b1;
    @(posedge clk);                          // Go sampled here
    go_edge = cycle_cnt;
    host_regs_valid_pulse <= '0;
    @(posedge clk);
    if (extra_go)
      host_regs_valid_pulse[go_reg_idx] <= 1'b1;  // Lands in the mul state
    @(posedge clk);
    host_regs_valid_pulse <= '0;
    @(negedge clk);
    compare_word("busy reg during job", host_regs_data_out[busy_reg_idx], 32'h1);
    compare_word("done reg during job", host_regs_data_out[done_reg_idx], 32'h0);
    compare_mask("host_regs_valid_out during job", host_regs_valid_out, busy_only);
    waited = 0;
    while (wr_cnt == wr_start && waited < job_limit) begin
      @(negedge clk);
      waited++;
    end
    if (wr_cnt == wr_start) begin
      err_cnt++;
      $display("error at %0t ns: no memory write within %0d cycles of go", $time, job_limit);
    end else begin
      compare_word("write latency in cycles", word_t'(wr_edge - go_edge), 32'd4);
      compare_addr("mem_addr on write", wr_addr, dst_line);
      compare_be("mem_be on write", wr_be, result_be);
      for (int w = 0; w < 4; w++)
        compare_word($sformatf("line 1 word %0d", w), mem_arr[dst_line][w*32 +: 32], exp_c[w]);
      for (int w = 4; w < words_per_line; w++)
        compare_word($sformatf("line 1 word %0d", w), mem_arr[dst_line][w*32 +: 32],
                     old_line[w*32 +: 32]);
    end
    @(negedge clk);                          // Status register one edge behind
    compare_word("busy reg after job", host_regs_data_out[busy_reg_idx], 32'h0);
    compare_word("done reg after job", host_regs_data_out[done_reg_idx], 32'h1);
    compare_bit("done valid bit after job", host_regs_valid_out[done_reg_idx], 1'b1);
  endtask

  // Drive a host write that must not start anything
  task automatic expect_no_job(input word_t go_val, input reg_mask_t pulse, input int cycles);
    int unsigned rd0;
    int unsigned wr0;
    rd0 = rd_cnt;
    wr0 = wr_cnt;
    @(posedge clk);
    host_regs[go_reg_idx] <= go_val;
    host_regs_valid_pulse <= pulse;
    @(posedge clk);
    host_regs_valid_pulse <= '0;
    repeat (2) @(negedge clk);               // Busy would show here for a taken go
    compare_word("busy reg while idle", host_regs_data_out[busy_reg_idx], 32'h0);
    repeat (cycles) @(negedge clk);
    if (rd_cnt != rd0 || wr_cnt != wr0) begin
      err_cnt++;
      $display("error at %0t ns: memory access without an accepted go", $time);
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic check_reset_state();
    int        errs;
    reg_mask_t busy_only;
    errs = err_cnt;
    busy_only = '0;
    busy_only[busy_reg_idx] = 1'b1;
    @(negedge clk);
    compare_bit("mem_rd", mem_rd, 1'b0);
    compare_bit("mem_wr", mem_wr, 1'b0);
    compare_be("mem_be", mem_be, '0);
    for (int r = 0; r < num_regs; r++)
      compare_word($sformatf("host reg %0d", r), host_regs_data_out[r], '0);
    compare_mask("host_regs_valid_out", host_regs_valid_out, busy_only);
    report_test("reset state", errs);
  endtask

  task automatic run_directed_product();
    int errs;
    errs = err_cnt;
    // Mixed signs as two's complement in 32 bits
    run_job(make_mat(32'd3, -32'sd2, 32'd7, 32'd5),
            make_mat(-32'sd4, 32'd6, 32'd1, -32'sd8), 1'b0);
    report_test("directed product", errs);
  endtask

  task automatic run_random_products();
    int   errs;
    mat_t a;
    mat_t b;
    errs = err_cnt;
    for (int n = 0; n < 20; n++) begin
      for (int e = 0; e < 4; e++) begin
        a[e] = lcg_next();
        b[e] = lcg_next();
      end
      if (n % 4 == 0) begin
        a[0] = 32'hffff_ffff;  // Product and sum both wrap
        b[0] = 32'h8000_0001;
      end
      run_job(a, b, 1'b0);
    end
    report_test("random products", errs);
  endtask

  task automatic check_status_flags();
    int errs;
    errs = err_cnt;
    run_job(make_mat(32'd1, 32'd0, 32'd0, 32'd1), make_mat(32'd9, 32'd8, 32'd7, 32'd6), 1'b0);
    run_job(make_mat(32'd2, 32'd2, 32'd2, 32'd2), make_mat(32'd0, 32'd1, 32'd1, 32'd0), 1'b0);
    for (int r = 0; r < 5; r++)
      compare_word($sformatf("reserved reg %0d", r), host_regs_data_out[r], '0);
    compare_word("go reg read-back", host_regs_data_out[go_reg_idx], '0);
    report_test("status", errs);
  endtask

  task automatic reject_bad_starts();
    int          errs;
    int unsigned wr0;
    reg_mask_t   go_pulse;
    reg_mask_t   other_pulse;
    errs = err_cnt;
    go_pulse = '0;
    go_pulse[go_reg_idx] = 1'b1;
    other_pulse = '0;
    other_pulse[4] = 1'b1;
    wr0 = wr_cnt;
    run_job(make_mat(32'd5, 32'd6, 32'd7, 32'd8), make_mat(32'd1, 32'd2, 32'd3, 32'd4), 1'b1);
    repeat (10) @(negedge clk);
    compare_word("writes for go while busy", word_t'(wr_cnt - wr0), 32'd1);
    expect_no_job(32'h2, go_pulse, 10);     // Bit 0 clear
    expect_no_job(32'h1, other_pulse, 10);  // Pulse on register 4
    expect_no_job(32'h1, '0, 10);           // Bit 0 held without a pulse
    report_test("ignored starts", errs);
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    rst_n                 = 1'b0;
    host_regs             = '0;
    host_regs_valid_pulse = '0;
    mem_rdata             = '0;
    fill_memory();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    run_directed_product();
    run_random_products();
    check_status_flags();
    reject_bad_starts();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* hw/mm_top.sv */
`timescale 1ns/1ps

module mm_top (
  input  logic                  clk,
  input  logic                  rst_n,

  // Scratch memory port
  output matmul_pkg::addr_t     mem_addr,               // Line address
  output matmul_pkg::line_t     mem_wdata,              // Full line, C in words 0-3
  output matmul_pkg::be_t       mem_be,                 // Byte enables for the write
  output logic                  mem_rd,
  output logic                  mem_wr,
  input  matmul_pkg::line_t     mem_rdata,              // One cycle after mem_rd

  // Host register port
  input  matmul_pkg::reg_file_t host_regs,
  input  matmul_pkg::reg_mask_t host_regs_valid_pulse,
  output matmul_pkg::reg_file_t host_regs_data_out,
  output matmul_pkg::reg_mask_t host_regs_valid_out
);
  import matmul_pkg::*;

  logic start;  // Host block to sequencer
  logic busy;   // Sequencer status
  logic done;

  mm_dp_if dp_if ();  // Sequencer to datapath strobes and result

  // --------------------------------------------------
  // Host registers
  // --------------------------------------------------

  mm_host_regs mm_host_regs_inst (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .host_regs             (host_regs),
    .host_regs_valid_pulse (host_regs_valid_pulse),
    .busy                  (busy),
    .done                  (done),
    .start                 (start),
    .host_regs_data_out    (host_regs_data_out),
    .host_regs_valid_out   (host_regs_valid_out)
  );

  // --------------------------------------------------
  // Sequencer and datapath
  // --------------------------------------------------

  mm_control mm_control_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_be    (mem_be),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .busy      (busy),
    .done      (done),
    .dp        (dp_if.ctrl)
  );

  mm_datapath mm_datapath_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .dp    (dp_if.dp)
  );

  // Upper words are masked off by mem_be anyway
  always_comb begin
    mem_wdata      = '0;
    mem_wdata[3:0] = dp_if.result;
  end

endmodule

/* hw/mm_datapath.sv */
`timescale 1ns/1ps

module mm_datapath (
  input  logic clk,
  input  logic rst_n,
  mm_dp_if.dp  dp
);
  import matmul_pkg::*;

  mat_t  op_a;      // A in row-major order
  mat_t  op_b;      // B in row-major order
  word_t prod [8];  // Pairs 2i and 2i+1 sum to C element i

  // --------------------------------------------------
  // Operand capture
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (dp.load) begin
      op_a <= dp.line_in[3:0];  // Words 0-3
      op_b <= dp.line_in[7:4];  // Words 4-7
    end
  end

  // --------------------------------------------------
  // Products kept modulo 2^32
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (dp.mul_en) begin
      prod[0] <= op_a[0] * op_b[0];  // a11*b11
      prod[1] <= op_a[1] * op_b[2];  // a12*b21
      prod[2] <= op_a[0] * op_b[1];  // a11*b12
      prod[3] <= op_a[1] * op_b[3];  // a12*b22
      prod[4] <= op_a[2] * op_b[0];  // a21*b11
      prod[5] <= op_a[3] * op_b[2];  // a22*b21
      prod[6] <= op_a[2] * op_b[1];  // a21*b12
      prod[7] <= op_a[3] * op_b[3];  // a22*b22
    end
  end

  // --------------------------------------------------
  // Pair sums into C
  // --------------------------------------------------

  // C also drives the low words of the write data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dp.result <= '0;
    end else if (dp.sum_en) begin
      dp.result[0] <= prod[0] + prod[1];  // c11
      dp.result[1] <= prod[2] + prod[3];  // c12
      dp.result[2] <= prod[4] + prod[5];  // c21
      dp.result[3] <= prod[6] + prod[7];  // c22 with the carry out dropped
    end
  end

endmodule

/* hw/mm_control.sv */
`timescale 1ns/1ps

module mm_control (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,      // Go command from the host block
  input  matmul_pkg::line_t mem_rdata,  // Valid the cycle after a read
  output matmul_pkg::addr_t mem_addr,
  output matmul_pkg::be_t   mem_be,
  output logic              mem_rd,
  output logic              mem_wr,
  output logic              busy,       // Read through write
  output logic              done,       // Sticky until the next accepted go
  mm_dp_if.ctrl             dp
);
  import matmul_pkg::*;

  mm_state_t state;       // Current sequencer state
  mm_state_t state_nxt;   // Next state
  logic      start_acc;   // Go taken while idle

  // Starts outside idle are dropped
  assign start_acc = (state == st_idle) & start;

  // --------------------------------------------------
  // State register
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // --------------------------------------------------
  // Next state and strobes
  // --------------------------------------------------

  always_comb begin
    state_nxt  = state;  // Hold by default
    mem_addr   = '0;
    mem_be     = '0;
    mem_rd     = 1'b0;
    mem_wr     = 1'b0;
    dp.load    = 1'b0;
    dp.mul_en  = 1'b0;
    dp.sum_en  = 1'b0;

    case (state)
      st_idle: begin
        if (start_acc) begin
          mem_rd    = 1'b1;      // Read issued in the go cycle itself
          mem_addr  = src_line;
          state_nxt = st_read;
        end
      end

      st_read: begin
        dp.load   = 1'b1;        // rdata of line 0 is on the bus now
        state_nxt = st_mul;
      end

      st_mul: begin
        dp.mul_en = 1'b1;        // Operands stable since the last edge
        state_nxt = st_sum;
      end

      st_sum: begin
        dp.sum_en = 1'b1;
        state_nxt = st_write;
      end

      st_write: begin
        mem_wr    = 1'b1;        // Single write cycle, result already registered
        mem_addr  = dst_line;
        mem_be    = result_be;   // Words 4-7 of line 1 left untouched
        state_nxt = st_idle;
      end

      default: begin
        state_nxt = st_idle;     // Recover from an illegal one-hot code
      end
    endcase
  end

  // Memory read data goes straight to the operand registers
  assign dp.line_in = mem_rdata;

  // --------------------------------------------------
  // Status
  // --------------------------------------------------

  assign busy = (state != st_idle);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (start_acc) begin
      done <= 1'b0;  // New job clears the old result flag
    end else if (state == st_write) begin
      done <= 1'b1;  // Set as the write completes
    end
  end

endmodule

/* hw/mm_host_regs.sv */
`timescale 1ns/1ps

module mm_host_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  matmul_pkg::reg_file_t host_regs,              // Latest host-written contents
  input  matmul_pkg::reg_mask_t host_regs_valid_pulse,  // One-cycle write strobe per register
  input  logic                  busy,                   // From the sequencer
  input  logic                  done,                   // Sticky flag from the sequencer
  output logic                  start,                  // Go command, combinational
  output matmul_pkg::reg_file_t host_regs_data_out,     // Read-back file
  output matmul_pkg::reg_mask_t host_regs_valid_out     // Read-back valid per register
);
  import matmul_pkg::*;

  reg_file_t data_out_nxt;  // Read-back file before the register

  // --------------------------------------------------
  // Start decode
  // --------------------------------------------------

  // Only a fresh write of the go register with bit 0 set counts
  assign start = host_regs_valid_pulse[go_reg_idx] & host_regs[go_reg_idx][0];

  // --------------------------------------------------
  // Status read-back
  // --------------------------------------------------

  always_comb begin
    data_out_nxt = '0;  // Reserved and go registers read as zero
    data_out_nxt[busy_reg_idx][0] = busy;
    data_out_nxt[done_reg_idx][0] = done;
  end

  // Status seen by the host lags the sequencer by one edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_regs_data_out <= '0;
    end else begin
      host_regs_data_out <= data_out_nxt;
    end
  end

  // Busy is always readable, done only once it is set
  always_comb begin
    host_regs_valid_out = '0;
    host_regs_valid_out[busy_reg_idx] = 1'b1;
    host_regs_valid_out[done_reg_idx] = host_regs_data_out[done_reg_idx][0];
  end

endmodule

/* hw/mm_dp_if.sv */
`timescale 1ns/1ps

// Sequencer to arithmetic datapath link
// Every enable is a one-cycle strobe acted on at the next rising edge
interface mm_dp_if;
  import matmul_pkg::*;

  logic  load;     // Capture line_in into the operand registers
  line_t line_in;  // Memory read data passed through the sequencer
  logic  mul_en;   // Register the eight products
  logic  sum_en;   // Register the four pair sums
  mat_t  result;   // Registered C, row-major

  // Sequencer side
  modport ctrl (
    output load,
    output line_in,
    output mul_en,
    output sum_en,
    input  result
  );

  // Datapath side
  modport dp (
    input  load,
    input  line_in,
    input  mul_en,
    input  sum_en,
    output result
  );

endinterface

/* hw/matmul_pkg.sv */
package matmul_pkg;

  // --------------------------------------------------
  // Widths and memory geometry
  // --------------------------------------------------
  localparam int word_w         = 32;  // One matrix element
  localparam int words_per_line = 8;   // Words in one scratch memory line
  localparam int bytes_per_line = 32;  // One byte-enable bit per byte
  localparam int addr_w         = 8;   // 256 lines in the scratch memory
  localparam int num_regs       = 32;  // Host register file depth

  // Host register map, 0 to 4 reserved and read as zero
  localparam int go_reg_idx   = 5;  // Bit 0 with a valid pulse starts a job
  localparam int busy_reg_idx = 6;  // Bit 0 high while a job runs
  localparam int done_reg_idx = 7;  // Bit 0 sticky after a job

  // --------------------------------------------------
  // Types
  // --------------------------------------------------
  typedef logic [word_w-1:0] word_t;
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [bytes_per_line-1:0] be_t;

  // Word 0 sits in the low bits of the line
  typedef logic [words_per_line-1:0][word_w-1:0] line_t;

  typedef logic [num_regs-1:0][word_w-1:0] reg_file_t;
  typedef logic [num_regs-1:0] reg_mask_t;  // One bit per host register

  // Elements 11, 12, 21, 22 at indices 0 to 3, row-major as in memory
  typedef logic [3:0][word_w-1:0] mat_t;

  // One-hot sequencer states
  typedef enum logic [4:0] {
    st_idle  = 5'b00001,  // Waiting for go
    st_read  = 5'b00010,  // Read data of line 0 returns
    st_mul   = 5'b00100,  // Eight products registered
    st_sum   = 5'b01000,  // Four sums registered
    st_write = 5'b10000   // C written to line 1
  } mm_state_t;

  // --------------------------------------------------
  // Memory layout
  // --------------------------------------------------
  localparam addr_t src_line = 8'd0;  // A in words 0-3, B in words 4-7
  localparam addr_t dst_line = 8'd1;  // C goes to words 0-3

  // Bytes 0-15, the four result words only
  localparam be_t result_be = 32'h0000_ffff;

endpackage
